/* hdl/ifu_cfg.svh */
// ========================================
// ifu configuration macros
// reset pc, queue depth and queue filler
// ========================================
`ifndef IFU_CFG_SVH
`define IFU_CFG_SVH

// first fetch address out of reset
`define IFU_RESET_PC 32'h0000_0000

// halfword entries, power of two and at least 4
`define IFU_QUEUE_DEPTH 8

// c.nop, loaded into every queue entry at reset
`define IFU_FILL_INST 16'h0001

`endif

/* hdl/ifu_pkg.sv */
// ========================================
// ifu package
// instruction views, decoded op and bundle
// ========================================
package ifu_pkg;

   // rv32 j-type layout, used for jal
   typedef struct packed {
      logic       imm20;
      logic [9:0] imm10_1;
      logic       imm11;
      logic [7:0] imm19_12;
      logic [4:0] rd;
      logic [6:0] opcode;
   } rv32_j_t;

   // rvc cj layout, used for c.j
   typedef struct packed {
      logic [2:0]  funct3;
      logic [10:0] target;
      logic [1:0]  op;
   } rvc_cj_t;

   // compressed view: upper halfword plus the cj halfword
   typedef struct packed {
      logic [15:0] upper;
      rvc_cj_t     cj;
   } rvc_pair_t;

   // one fetched word, two ways to read it
   typedef union packed {
      rv32_j_t   j;
      rvc_pair_t c;
   } inst_u;

   typedef enum logic [1:0] {
      OP_SEQ = 2'd0,
      OP_JAL = 2'd1,
      OP_CJ  = 2'd2
   } op_e;

   typedef struct packed {
      op_e         op;
      logic        is_32;
      logic [20:0] offset;
      inst_u       inst;
   } dec_t;

endpackage

/* hdl/ifu_ifs.sv */
// ========================================
// ifu internal interfaces
// fetch to decode, decode to execute
// ========================================
`timescale 1ns/1ns

interface fetch_if;
   logic        valid;
   logic [31:0] inst;
   logic        is_32;
   logic        take;

   modport src (output valid, output inst, output is_32, input take);
   modport dst (input valid, input inst, input is_32);
   // execute only consumes
   modport acc (output take);
endinterface

interface dec_if;
   import ifu_pkg::*;
   logic valid;
   dec_t bundle;

   modport out (output valid, output bundle);
   modport in  (input valid, input bundle);
endinterface

/* hdl/ifu_prefetch.sv */
// ========================================
// ifu prefetch
// halfword queue fed by word fetches,
// hands out 16/32-bit instructions
// ========================================
`timescale 1ns/1ns
`include "ifu_cfg.svh"

module ifu_prefetch (
   input  logic        clk,
   input  logic        rst_n,
   output logic        code_req,
   output logic [31:0] code_addr,
   input  logic [31:0] code_rdata,
   input  logic        code_ready,
   input  logic        redirect,
   input  logic [31:0] target,
   fetch_if.src        fch
);

   localparam int PTR_W = $clog2(`IFU_QUEUE_DEPTH);

   // ========================================
   // state
   // ========================================
   logic [15:0]             iq [`IFU_QUEUE_DEPTH];
   logic [PTR_W-1:0]        wr_ptr;
   logic [PTR_W-1:0]        rd_ptr;
   logic [PTR_W-1:0]        wr_ptr_p1;
   logic [PTR_W-1:0]        rd_ptr_p1;
   logic [PTR_W-1:0]        rd_step;
   // held halfwords, -1 right after an odd redirect
   logic signed [PTR_W+1:0] fill;
   logic signed [PTR_W+1:0] add_hw;
   logic signed [PTR_W+1:0] sub_hw;
   logic signed [PTR_W+1:0] pend_hw;
   logic [31:0]             addr_r;
   logic                    pend;
   logic                    started;
   logic                    wr_en;
   logic                    room;
   logic                    is_32;

   assign wr_ptr_p1 = wr_ptr + 1'b1;
   assign rd_ptr_p1 = rd_ptr + 1'b1;

   // ========================================
   // read side
   // ========================================
   // length from the low bits of the first halfword
   assign is_32     = (iq[rd_ptr][1:0] == 2'b11);
   assign fch.is_32 = is_32;
   assign fch.inst  = {iq[rd_ptr_p1], iq[rd_ptr]};
   // need two halfwords for a 32-bit one
   assign fch.valid = (fill > 0) && (!is_32 || fill > 1);
   assign rd_step   = is_32 ? PTR_W'(2) : PTR_W'(1);

   // ========================================
   // bus side
   // ========================================
   // returned word, dropped when a redirect hits
   assign wr_en   = pend & code_ready & ~redirect;
   // count the in-flight word as already stored
   assign pend_hw = pend ? 2 : 0;
   assign room    = (fill + pend_hw) <= (`IFU_QUEUE_DEPTH - 2);

   assign code_req  = started & room;
   assign code_addr = addr_r;

   assign add_hw = wr_en ? 2 : 0;
   assign sub_hw = fch.take ? (is_32 ? 2 : 1) : 0;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         started <= 1'b0;
         pend    <= 1'b0;
         addr_r  <= `IFU_RESET_PC;
      end else begin
         started <= 1'b1;
         if (redirect) begin
            // cancel data in flight, restart at the target word
            pend   <= 1'b0;
            addr_r <= {target[31:2], 2'b00};
         end else if (code_ready) begin
            pend <= code_req;
            if (code_req)
               addr_r <= addr_r + 32'd4;
         end
      end
   end

   // pointers and fill level
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         fill   <= '0;
      end else if (redirect) begin
         wr_ptr <= '0;
         // skip the low halfword for an odd target
         rd_ptr <= {{(PTR_W-1){1'b0}}, target[1]};
         fill   <= target[1] ? -1 : 0;
      end else begin
         if (wr_en)
            wr_ptr <= wr_ptr + PTR_W'(2);
         if (fch.take)
            rd_ptr <= rd_ptr + rd_step;
         fill <= fill + add_hw - sub_hw;
      end
   end

   // queue entries, one word lands as two halfwords
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < `IFU_QUEUE_DEPTH; i++)
            iq[i] <= `IFU_FILL_INST;
      end else if (wr_en) begin
         iq[wr_ptr]    <= code_rdata[15:0];
         iq[wr_ptr_p1] <= code_rdata[31:16];
      end
   end

endmodule

/* hdl/ifu_decode.sv */
// ========================================
// ifu decode
// classifies seq / jal / c.j and
// rebuilds the jump offset
// ========================================
`timescale 1ns/1ns

module ifu_decode (
   fetch_if.dst fch,
   dec_if.out   dec
);
   import ifu_pkg::*;

   inst_u       word;
   inst_u       inst_out;
   logic [20:0] jal_off;
   logic [20:0] cj_off;
   logic [10:0] t;
   op_e         op;

   assign word = fch.inst;
   assign t    = word.c.cj.target;

   // j-type immediate, bit 0 implied
   assign jal_off = {word.j.imm20, word.j.imm19_12, word.j.imm11,
                     word.j.imm10_1, 1'b0};

   // cj field order 11|4|9:8|10|6|7|3:1|5
   assign cj_off = {{9{t[10]}}, t[10], t[6], t[8:7], t[4], t[5], t[0],
                    t[9], t[3:1], 1'b0};

   always_comb begin
      if (fch.is_32 && word.j.opcode == 7'b1101111)
         op = OP_JAL;
      else if (!fch.is_32 && word.c.cj.op == 2'b01 && word.c.cj.funct3 == 3'b101)
         op = OP_CJ;
      else
         op = OP_SEQ;
   end

   always_comb begin
      inst_out = word;
      // upper halfword belongs to the next instruction
      if (!fch.is_32)
         inst_out.c.upper = 16'h0000;
   end

   assign dec.valid         = fch.valid;
   assign dec.bundle.op     = op;
   assign dec.bundle.is_32  = fch.is_32;
   assign dec.bundle.inst   = inst_out;
   assign dec.bundle.offset = (op == OP_JAL) ? jal_off :
                              (op == OP_CJ)  ? cj_off  : 21'd0;

endmodule

/* hdl/ifu_branch_exec.sv */
// ========================================
// ifu execute
// pc register, instruction accept and
// redirect on jumps
// ========================================
`timescale 1ns/1ns
`include "ifu_cfg.svh"

module ifu_branch_exec (
   input  logic           clk,
   input  logic           rst_n,
   input  logic           stall,
   dec_if.in              dec,
   fetch_if.acc           fch,
   output logic           redirect,
   output logic [31:0]    target,
   output logic           accept,
   output logic [31:0]    pc,
   output ifu_pkg::inst_u inst
);
   import ifu_pkg::*;

   logic [31:0] pc_r;
   logic        take;
   logic        is_jump;

   // consume whenever something is there and the core runs
   assign take     = dec.valid & ~stall;
   assign fch.take = take;
   assign accept   = take;

   assign is_jump  = (dec.bundle.op != OP_SEQ);
   // offset is relative to the jump itself
   assign target   = pc_r + {{11{dec.bundle.offset[20]}}, dec.bundle.offset};
   assign redirect = take & is_jump;

   assign pc   = pc_r;
   assign inst = dec.bundle.inst;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         pc_r <= `IFU_RESET_PC;
      end else if (take) begin
         if (is_jump)
            pc_r <= target;
         else
            pc_r <= pc_r + (dec.bundle.is_32 ? 32'd4 : 32'd2);
      end
   end

endmodule

/* hdl/ifu_retire.sv */
// ========================================
// ifu retire
// registered retire record and counter
// ========================================
`timescale 1ns/1ns
`include "ifu_cfg.svh"

module ifu_retire (
   input  logic           clk,
   input  logic           rst_n,
   input  logic           accept,
   input  logic [31:0]    pc,
   input  ifu_pkg::inst_u inst,
   output logic           retire_valid,
   output logic [31:0]    retire_pc,
   output ifu_pkg::inst_u retire_inst,
   output logic [15:0]    retire_count
);

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         retire_valid <= 1'b0;
         retire_count <= 16'd0;
         retire_pc    <= `IFU_RESET_PC;
      end else begin
         // one pulse per accepted instruction
         retire_valid <= accept;
         if (accept) begin
            retire_pc    <= pc;
            retire_count <= retire_count + 16'd1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (accept)
         retire_inst <= inst;
   end

endmodule

/* hdl/ifu_top.sv */
// ========================================
// ifu top
// prefetch, decode, execute and retire
// ========================================
`timescale 1ns/1ns

module ifu_top (
   input  logic           clk,
   input  logic           rst_n,
   input  logic           stall,
   output logic           code_req,
   output logic [31:0]    code_addr,
   input  logic [31:0]    code_rdata,
   input  logic           code_ready,
   output logic           retire_valid,
   output logic [31:0]    retire_pc,
   output ifu_pkg::inst_u retire_inst,
   output logic [15:0]    retire_count
);
   import ifu_pkg::*;

   fetch_if fch ();
   dec_if   dec ();

   // execute to prefetch
   logic        redirect;
   logic [31:0] target;
   // execute to retire
   logic        accept;
   logic [31:0] ex_pc;
   inst_u       ex_inst;

   ifu_prefetch u_prefetch (
      .clk        (clk),
      .rst_n      (rst_n),
      .code_req   (code_req),
      .code_addr  (code_addr),
      .code_rdata (code_rdata),
      .code_ready (code_ready),
      .redirect   (redirect),
      .target     (target),
      .fch        (fch.src)
   );

   ifu_decode u_decode (
      .fch (fch.dst),
      .dec (dec.out)
   );

   ifu_branch_exec u_exec (
      .clk      (clk),
      .rst_n    (rst_n),
      .stall    (stall),
      .dec      (dec.in),
      .fch      (fch.acc),
      .redirect (redirect),
      .target   (target),
      .accept   (accept),
      .pc       (ex_pc),
      .inst     (ex_inst)
   );

   ifu_retire u_retire (
      .clk          (clk),
      .rst_n        (rst_n),
      .accept       (accept),
      .pc           (ex_pc),
      .inst         (ex_inst),
      .retire_valid (retire_valid),
      .retire_pc    (retire_pc),
      .retire_inst  (retire_inst),
      .retire_count (retire_count)
   );

endmodule

/* test/ifu_assertions.sv */
// ========================================
// ifu assertions
// code bus alignment and retire sanity,
// bound onto the ifu top level
// ========================================
`timescale 1ns/1ns

module ifu_assertions (
   input logic        clk,
   input logic        rst_n,
   input logic        code_req,
   input logic [31:0] code_addr,
   input logic        retire_valid,
   input logic [31:0] retire_pc
);

   // number of assertion failures so far
   int unsigned assert_errors = 0;

   // fetches are whole words
   a_code_addr_aligned : assert property (@(posedge clk) disable iff (!rst_n)
      code_req |-> (code_addr[1:0] == 2'b00))
      else begin
         $error("code_addr not word aligned while code_req is high");
         assert_errors++;
      end

   // rv32ic pcs are at least halfword aligned
   a_retire_pc_aligned : assert property (@(posedge clk) disable iff (!rst_n)
      retire_pc[0] == 1'b0)
      else begin
         $error("retire_pc is not halfword aligned");
         assert_errors++;
      end

   // no fetch has returned yet, so nothing can retire
   a_no_early_retire : assert property (@(posedge clk) $rose(rst_n) |-> !retire_valid)
      else begin
         $error("retire_valid high in the first cycle after reset release");
         assert_errors++;
      end

endmodule

bind ifu_top ifu_assertions i_assert (.*);

/* test/ifu_tb.sv */
// ========================================
// ifu testbench
// random rv32ic program in a 1 KiB code
// memory with wait states, random stall,
// retire stream checked against next_pc
// ========================================
`timescale 1ns/1ns
`include "ifu_cfg.svh"

module ifu_tb;
   import ifu_pkg::*;

   localparam int RESET_CYCLES = 16;
   localparam int NUM_RETIRE   = 300;
   localparam int TIMEOUT      = RESET_CYCLES + NUM_RETIRE * 24;
   // body ends here, then one jal back to the reset pc
   localparam int PROG_END     = 'h3c0;

   logic        clk;
   logic        rst_n;
   logic        stall;
   logic        code_req;
   logic [31:0] code_addr;
   logic [31:0] code_rdata;
   logic        code_ready;
   logic        retire_valid;
   logic [31:0] retire_pc;
   inst_u       retire_inst;
   logic [15:0] retire_count;

   // code image as words and as halfwords
   logic [31:0] mem [256];
   logic [15:0] hw [512];
   logic [31:0] rd_addr;
   logic        addr_taken;
   logic        data_given;
   logic [31:0] exp_pc;
   logic [15:0] seen;
   int          cycles;

   ifu_top i_dut (.*);

   always #4 clk = ~clk;

   // ========================================
   // code memory model
   // ========================================
   // data phase reads the last accepted address
   assign code_rdata = mem[rd_addr[9:2]];

   always @(posedge clk) begin
      if (code_req && code_ready) begin
         rd_addr    <= code_addr;
         addr_taken <= 1'b1;
      end
      // first data phase done
      if (addr_taken && code_ready)
         data_given <= 1'b1;
   end

   // ========================================
   // encoders and reference model
   // ========================================
   function automatic logic [31:0] make_jal(input logic [20:0] off);
      return {off[20], off[10:1], off[11], off[19:12], 5'd1, 7'b1101111};
   endfunction

   // cj target order 11|4|9:8|10|6|7|3:1|5
   function automatic logic [15:0] make_cj(input logic [11:0] off);
      return {3'b101, off[11], off[4], off[9:8], off[10], off[6], off[7], off[3:1],
              off[5], 2'b01};
   endfunction

   function automatic logic [15:0] half_at(input logic [31:0] image [256],
                                           input logic [31:0] a);
      logic [31:0] w;
      w = image[a[9:2]];
      return a[1] ? w[31:16] : w[15:0];
   endfunction

   // retired word with the upper half zero for compressed
   function automatic inst_u word_at(input logic [31:0] image [256],
                                     input logic [31:0] pc);
      logic [15:0] lo;
      lo = half_at(image, pc);
      if (lo[1:0] == 2'b11)
         return {half_at(image, pc + 32'd2), lo};
      return {16'h0000, lo};
   endfunction

   function automatic logic [31:0] next_pc(input logic [31:0] pc,
                                           input logic [31:0] image [256]);
      logic [31:0] w;
      w = word_at(image, pc);
      if (w[1:0] == 2'b11) begin
         if (w[6:0] == 7'b1101111)
            return pc + {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
         return pc + 32'd4;
      end
      if (w[15:13] == 3'b101 && w[1:0] == 2'b01)
         return pc + {{20{w[12]}}, w[12], w[8], w[10:9], w[6], w[7], w[2], w[11],
                      w[5:3], 1'b0};
      return pc + 32'd2;
   endfunction

   // kinds 0 rvc, 1 rv32, 2 c.j, 3 jal, 4 closing jal
   task automatic build_program();
      int          starts[$];
      int          kinds[$];
      int          pc;
      int          j;
      int          off;
      logic [31:0] v;
      for (int a = 0; a < 512; a++)
         hw[a] = {a[8:0], 7'h00};
      pc = 0;
      while (pc < PROG_END) begin
         v = $urandom % 12;
         starts.push_back(pc);
         kinds.push_back(v < 5 ? 0 : v < 10 ? 1 : v < 11 ? 2 : 3);
         pc += (kinds[$] == 0 || kinds[$] == 2) ? 2 : 4;
      end
      starts.push_back(pc);
      kinds.push_back(4);
      for (int i = 0; i < starts.size(); i++) begin
         // forward jumps land on a later instruction start
         j = i + 1 + ($urandom % 6);
         if (j >= starts.size())
            j = starts.size() - 1;
         off = (kinds[i] == 4) ? -starts[i] : starts[j] - starts[i];
         v = $urandom;
         case (kinds[i])
            0: begin
               v[1:0]   = (v[1:0] == 2'b11) ? 2'b10 : v[1:0];
               v[15:13] = (v[1:0] == 2'b01 && v[15:13] == 3'b101) ? 3'b000 : v[15:13];
            end
            1: begin
               v[1:0] = 2'b11;
               v[6:0] = (v[6:0] == 7'b1101111) ? 7'b0010011 : v[6:0];
            end
            2: v[15:0] = make_cj(off[11:0]);
            default: v = make_jal(off[20:0]);
         endcase
         hw[starts[i] / 2] = v[15:0];
         if (kinds[i] == 1 || kinds[i] >= 3)
            hw[starts[i] / 2 + 1] = v[31:16];
      end
      for (int w = 0; w < 256; w++)
         mem[w] = {hw[2 * w + 1], hw[2 * w]};
   endtask

   // ========================================
   // checks
   // ========================================
   task automatic abort_run();
      $display("CHECKS FAILED");
      $fatal(1, "run stopped at the first error");
   endtask

   task automatic check_pc(input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp) begin
         $display("Mismatch retire_pc: got %h expected %h", got, exp);
         abort_run();
      end
   endtask

   task automatic check_inst(input inst_u got, input inst_u exp);
      if (got !== exp) begin
         $display("Mismatch retire_inst: got %h expected %h", got, exp);
         abort_run();
      end
   endtask

   task automatic check_count(input logic [15:0] got, input logic [15:0] exp);
      if (got !== exp) begin
         $display("Mismatch retire_count: got %h expected %h", got, exp);
         abort_run();
      end
   endtask

   // ========================================
   // stimulus, compare and timeout
   // ========================================
   initial begin
      void'($urandom(32'hd998_16d1));
      clk        = 1'b0;
      rst_n      = 1'b0;
      stall      = 1'b0;
      code_ready = 1'b0;
      rd_addr    = 32'd0;
      addr_taken = 1'b0;
      data_given = 1'b0;
      cycles     = 0;
      build_program();
      repeat (RESET_CYCLES) @(posedge clk);
      rst_n <= 1'b1;
      forever begin
         @(posedge clk);
         code_ready <= ($urandom % 4) != 0;
         stall      <= ($urandom % 5) == 0;
      end
   end

   initial begin
      exp_pc = `IFU_RESET_PC;
      seen   = 16'd0;
      @(posedge rst_n);
      while (seen < NUM_RETIRE) begin
         @(posedge clk);
         if (retire_valid) begin
            if (!data_given) begin
               $display("Retirement seen before the first code fetch returned");
               abort_run();
            end
            seen = seen + 16'd1;
            check_pc(retire_pc, exp_pc);
            check_inst(retire_inst, word_at(mem, exp_pc));
            check_count(retire_count, seen);
            exp_pc = next_pc(exp_pc, mem);
         end
      end
      if (i_dut.i_assert.assert_errors == 0) begin
         $display("ALL CHECKS PASSED");
         $finish;
      end else begin
         $display("Assertion failures during the run: %0d", i_dut.i_assert.assert_errors);
         abort_run();
      end
   end

   // cycle limit and bound assertion watch
   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (i_dut.i_assert.assert_errors != 0) begin
         $display("An assertion on the DUT failed in the previous cycle");
         abort_run();
      end else if (cycles >= TIMEOUT) begin
         $display("Retirement stalled: %0d of %0d instructions retired", seen, NUM_RETIRE);
         abort_run();
      end
   end

endmodule

/* vlog.f */
+incdir+hdl
hdl/ifu_pkg.sv
hdl/ifu_ifs.sv
hdl/ifu_prefetch.sv
hdl/ifu_decode.sv
hdl/ifu_branch_exec.sv
hdl/ifu_retire.sv
hdl/ifu_top.sv
test/ifu_assertions.sv
test/ifu_tb.sv

/* Bender.yml */
package:
  name: ifu

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/ifu_pkg.sv
      - hdl/ifu_ifs.sv
      - hdl/ifu_prefetch.sv
      - hdl/ifu_decode.sv
      - hdl/ifu_branch_exec.sv
      - hdl/ifu_retire.sv
      - hdl/ifu_top.sv
      - test/ifu_assertions.sv
      - test/ifu_tb.sv
